// File: hf_pkg.sv
// History buffer shared types
package hf_pkg;

	localparam int unsigned XLEN   = 32; // data and address width.
	localparam int unsigned REG_AW = 5;  // register index width.

	// one in-flight instruction, 134 bits.
	typedef struct packed {
		logic              finished;  // writeback seen.
		logic [XLEN-1:0]   cause;     // zero means clean.
		logic [XLEN-1:0]   mtval;     // fault address.
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   old_value; // rd contents before dispatch.
	} hf_entry_t;

	// controller states.
	typedef enum logic [1:0] {
		ST_RUN,     // dispatch, writeback and retirement.
		ST_KILL,    // kill pulse, first restore read.
		ST_RESTORE, // one register write per cycle.
		ST_REPORT   // exception out, buffer emptied.
	} hf_state_t;

endpackage

// File: hf_store_if.sv
// History buffer internal bus
`timescale 1ns/1ps

interface hf_store_if #(
	parameter int unsigned HF_DEPTH = 16
) ();

	localparam int unsigned PTR_W = $clog2(HF_DEPTH);

	// controller requests.
	logic push;
	logic pop;
	logic walk_start;
	logic walk_step;
	logic flush;

	// pointer state.
	logic [PTR_W-1:0] head_idx;
	logic [PTR_W-1:0] tail_idx;
	logic [PTR_W-1:0] walk_idx;
	logic             full;
	logic             empty;
	logic             walk_at_head;

	// entry read ports.
	hf_pkg::hf_entry_t head_entry;
	hf_pkg::hf_entry_t walk_entry;

	modport ctrl (
		output push, pop, walk_start, walk_step, flush,
		input  full, empty, walk_at_head, head_entry, walk_entry
	);

	modport ptr (
		input  push, pop, walk_start, walk_step, flush,
		output head_idx, tail_idx, walk_idx, full, empty, walk_at_head
	);

	modport store (
		input  push, pop, walk_start, flush, head_idx, tail_idx, walk_idx,
		output head_entry, walk_entry
	);

endinterface

// File: hf_entry_store.sv
// History buffer entry array
`timescale 1ns/1ps

module hf_entry_store #(
	parameter int unsigned HF_DEPTH = 16
) (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	hf_store_if.store                  bus,
	input  logic [hf_pkg::XLEN-1:0]    dec_pc_i,
	input  logic [hf_pkg::REG_AW-1:0]  dec_rd_i,
	input  logic [hf_pkg::XLEN-1:0]    dec_old_value_i,
	input  logic                       wb_valid_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_pc_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_cause_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_mtval_i,
	output logic                       wb_hit_o
);

	localparam int unsigned PTR_W = $clog2(HF_DEPTH);

	hf_pkg::hf_entry_t entries [HF_DEPTH];
	logic [HF_DEPTH-1:0] valid_q;
	logic                frozen_q; // set from walk start until flush.
	logic                wb_match;
	logic [PTR_W-1:0]    wb_idx;

	// pc lookup over live, unfinished entries.
	// pcs in flight are unique, so at most one matches.
	always_comb begin
		wb_match = 1'b0;
		wb_idx = '0;
		for (int i = 0; i < HF_DEPTH; i++) begin
			if (valid_q[i] && !entries[i].finished && entries[i].pc == wb_pc_i) begin
				wb_match = 1'b1;
				wb_idx = PTR_W'(i);
			end
		end
	end

	// writebacks land only while the buffer runs normally.
	assign wb_hit_o = wb_valid_i && wb_match && !frozen_q;

	// payload writes.
	always_ff @(posedge clk_i) begin
		if (bus.push) begin
			entries[bus.tail_idx] <= '{
				finished:  1'b0,
				cause:     '0,
				mtval:     '0,
				pc:        dec_pc_i,
				rd:        dec_rd_i,
				old_value: dec_old_value_i
			};
		end
		if (wb_hit_o) begin
			entries[wb_idx].finished <= 1'b1;
			entries[wb_idx].cause <= wb_cause_i;
			entries[wb_idx].mtval <= wb_mtval_i;
		end
	end

	// live bits and recovery freeze.
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			frozen_q <= 1'b0;
		end else begin
			if (bus.flush) begin
				valid_q <= '0; // whole window discarded.
			end else begin
				if (bus.pop) valid_q[bus.head_idx] <= 1'b0;  // retired.
				if (bus.push) valid_q[bus.tail_idx] <= 1'b1; // dispatched.
			end

			if (bus.walk_start) begin
				frozen_q <= 1'b1;
			end else if (bus.flush) begin
				frozen_q <= 1'b0;
			end
		end
	end

	// read ports.
	assign bus.head_entry = entries[bus.head_idx];
	assign bus.walk_entry = entries[bus.walk_idx];

endmodule

// File: hf_ptr_unit.sv
// History buffer pointers
`timescale 1ns/1ps

module hf_ptr_unit #(
	parameter int unsigned HF_DEPTH = 16
) (
	input  logic   clk_i,
	input  logic   rst_n_i,
	hf_store_if.ptr bus
);

	localparam int unsigned PTR_W = $clog2(HF_DEPTH);

	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W-1:0] walk_q;
	logic [PTR_W:0]   count_q;
	logic [PTR_W:0]   count_d;
	logic             full_q;
	logic             empty_q;

	always_comb begin
		count_d = count_q;
		if (bus.flush) begin
			count_d = '0;
		end else if (bus.push && !bus.pop) begin
			count_d = count_q + 1'b1;
		end else if (bus.pop && !bus.push) begin
			count_d = count_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			head_q <= '0;
			tail_q <= '0;
			walk_q <= '0;
			count_q <= '0;
			full_q <= 1'b0;
			empty_q <= 1'b1;
		end else begin
			if (bus.pop) head_q <= head_q + 1'b1; // wraps at depth.
			if (bus.flush) begin
				tail_q <= head_q;
			end else if (bus.push) begin
				tail_q <= tail_q + 1'b1;
			end

			// newest entry, counting a dispatch in the same cycle.
			if (bus.walk_start) begin
				walk_q <= bus.push ? tail_q : tail_q - 1'b1;
			end else if (bus.walk_step) begin
				walk_q <= walk_q - 1'b1;
			end

			count_q <= count_d;
			full_q <= (count_d == (PTR_W + 1)'(HF_DEPTH));
			empty_q <= (count_d == '0);
		end
	end

	assign bus.head_idx = head_q;
	assign bus.tail_idx = tail_q;
	assign bus.walk_idx = walk_q;
	assign bus.full = full_q;
	assign bus.empty = empty_q;
	assign bus.walk_at_head = (walk_q == head_q);

endmodule

// File: hf_control_fsm.sv
// History buffer controller
`timescale 1ns/1ps

module hf_control_fsm (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       dec_valid_i,
	input  logic                       wb_hit_i,
	hf_store_if.ctrl                   bus,
	output logic                       stall_o,
	output logic                       kill_o,
	output logic [hf_pkg::XLEN-1:0]    kill_pc_o,
	output logic                       retire_o,
	output logic [hf_pkg::XLEN-1:0]    retire_pc_o,
	output logic                       rec_we_o,
	output logic [hf_pkg::REG_AW-1:0]  rec_rd_o,
	output logic [hf_pkg::XLEN-1:0]    rec_value_o,
	output logic                       exc_valid_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mepc_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mcause_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mtval_o
);

	hf_pkg::hf_state_t state_q;
	logic stall_q;
	logic last_q;  // head entry already written back.
	logic check_q; // head may have changed, look at it.
	logic head_ready;
	logic head_fault;
	logic head_clean;
	logic rec_load;
	logic exc_load;

	// head status only changes after a writeback or a retire.
	assign head_ready = check_q && !bus.empty && bus.head_entry.finished;
	assign head_fault = head_ready && (bus.head_entry.cause != '0);
	assign head_clean = head_ready && (bus.head_entry.cause == '0);

	assign rec_load = (state_q == hf_pkg::ST_KILL) ||
		(state_q == hf_pkg::ST_RESTORE && !last_q);
	assign exc_load = (state_q == hf_pkg::ST_RESTORE) && last_q;

	assign bus.push = dec_valid_i && !stall_o;
	assign bus.pop = (state_q == hf_pkg::ST_RUN) && head_clean;
	assign bus.walk_start = (state_q == hf_pkg::ST_RUN) && head_fault;
	assign bus.walk_step = rec_load && !bus.walk_at_head; // never past the head.
	assign bus.flush = (state_q == hf_pkg::ST_REPORT);

	assign stall_o = stall_q || bus.full;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= hf_pkg::ST_RUN;
			stall_q <= 1'b0;
			last_q <= 1'b0;
			check_q <= 1'b0;
			kill_o <= 1'b0;
			retire_o <= 1'b0;
			rec_we_o <= 1'b0;
			exc_valid_o <= 1'b0;
		end else begin
			kill_o <= bus.walk_start;
			retire_o <= bus.pop;
			rec_we_o <= rec_load;
			exc_valid_o <= exc_load;
			if (rec_load) last_q <= bus.walk_at_head;
			case (state_q)
				hf_pkg::ST_RUN: begin
					check_q <= wb_hit_i || bus.pop;
					if (bus.walk_start) begin
						state_q <= hf_pkg::ST_KILL;
						stall_q <= 1'b1; // held through the report.
					end
				end
				hf_pkg::ST_KILL: begin
					check_q <= 1'b0;
					state_q <= hf_pkg::ST_RESTORE;
				end
				hf_pkg::ST_RESTORE: begin
					if (last_q) state_q <= hf_pkg::ST_REPORT;
				end
				default: begin
					state_q <= hf_pkg::ST_RUN;
					stall_q <= 1'b0;
					last_q <= 1'b0;
				end
			endcase
		end
	end

	// output payloads.
	always_ff @(posedge clk_i) begin
		if (bus.walk_start) kill_pc_o <= bus.head_entry.pc;
		if (bus.pop) retire_pc_o <= bus.head_entry.pc;
		if (rec_load) begin
			rec_rd_o <= bus.walk_entry.rd;
			rec_value_o <= bus.walk_entry.old_value;
		end
		if (exc_load) begin
			exc_mepc_o <= bus.head_entry.pc;
			exc_mcause_o <= bus.head_entry.cause;
			exc_mtval_o <= bus.head_entry.mtval;
		end
	end

endmodule

// File: history_buffer_top.sv
// History buffer top level
`timescale 1ns/1ps

module history_buffer_top #(
	parameter int unsigned HF_DEPTH = 16
) (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       dec_valid_i,
	input  logic [hf_pkg::XLEN-1:0]    dec_pc_i,
	input  logic [hf_pkg::REG_AW-1:0]  dec_rd_i,
	input  logic [hf_pkg::XLEN-1:0]    dec_old_value_i,
	input  logic                       wb_valid_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_pc_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_cause_i,
	input  logic [hf_pkg::XLEN-1:0]    wb_mtval_i,
	output logic                       stall_o,
	output logic                       kill_o,
	output logic [hf_pkg::XLEN-1:0]    kill_pc_o,
	output logic                       retire_o,
	output logic [hf_pkg::XLEN-1:0]    retire_pc_o,
	output logic                       rec_we_o,
	output logic [hf_pkg::REG_AW-1:0]  rec_rd_o,
	output logic [hf_pkg::XLEN-1:0]    rec_value_o,
	output logic                       exc_valid_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mepc_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mcause_o,
	output logic [hf_pkg::XLEN-1:0]    exc_mtval_o
);

	logic wb_hit;

	hf_store_if #(.HF_DEPTH(HF_DEPTH)) store_bus ();

	hf_entry_store #(.HF_DEPTH(HF_DEPTH)) i_entry_store (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.bus             (store_bus.store),
		.dec_pc_i        (dec_pc_i),
		.dec_rd_i        (dec_rd_i),
		.dec_old_value_i (dec_old_value_i),
		.wb_valid_i      (wb_valid_i),
		.wb_pc_i         (wb_pc_i),
		.wb_cause_i      (wb_cause_i),
		.wb_mtval_i      (wb_mtval_i),
		.wb_hit_o        (wb_hit)
	);

	hf_ptr_unit #(.HF_DEPTH(HF_DEPTH)) i_ptr_unit (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.bus     (store_bus.ptr)
	);

	hf_control_fsm i_control_fsm (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.dec_valid_i  (dec_valid_i),
		.wb_hit_i     (wb_hit),
		.bus          (store_bus.ctrl),
		.stall_o      (stall_o),
		.kill_o       (kill_o),
		.kill_pc_o    (kill_pc_o),
		.retire_o     (retire_o),
		.retire_pc_o  (retire_pc_o),
		.rec_we_o     (rec_we_o),
		.rec_rd_o     (rec_rd_o),
		.rec_value_o  (rec_value_o),
		.exc_valid_o  (exc_valid_o),
		.exc_mepc_o   (exc_mepc_o),
		.exc_mcause_o (exc_mcause_o),
		.exc_mtval_o  (exc_mtval_o)
	);

endmodule

// File: history_buffer_sva.sv
// History buffer protocol assertions
`timescale 1ns/1ps

module history_buffer_sva (
	input logic clk_i,
	input logic rst_n_i,
	input logic dec_valid_i,
	input logic stall_o,
	input logic kill_o,
	input logic rec_we_o,
	input logic exc_valid_o
);

	int unsigned fail_count = 0; // failed assertions so far.

	// decode must hold while stalled.
	a_no_dispatch_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(dec_valid_i && stall_o))
	else begin
		$error("dispatch strobe while stall_o is high");
		fail_count++;
	end

	a_kill_then_restore: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		kill_o |=> rec_we_o)
	else begin
		$error("kill_o not followed by a restore write");
		fail_count++;
	end

	a_exc_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		exc_valid_o |=> !exc_valid_o)
	else begin
		$error("exc_valid_o longer than one cycle");
		fail_count++;
	end

endmodule

// File: hf_checker.sv
// History buffer result checker
`timescale 1ns/1ps

module hf_checker (
	input logic        clk_i,
	input logic        rst_n_i,
	input logic        stall_i,
	input logic        kill_i,
	input logic [31:0] kill_pc_i,
	input logic        retire_i,
	input logic [31:0] retire_pc_i,
	input logic        rec_we_i,
	input logic [4:0]  rec_rd_i,
	input logic [31:0] rec_value_i,
	input logic        exc_valid_i,
	input logic [31:0] exc_mepc_i,
	input logic [31:0] exc_mcause_i,
	input logic [31:0] exc_mtval_i
);

	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	logic [31:0] retire_q [$]; // expected events, oldest first.
	logic [31:0] kill_q [$];
	logic [36:0] rec_q [$];    // {rd, old value}.
	logic [95:0] exc_q [$];    // {mepc, mcause, mtval}.
	logic [95:0] want;

	task automatic note(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic mismatch(input string what, input logic [95:0] got,
		input logic [95:0] exp);
		$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic expect_retire(input logic [31:0] pc);
		retire_q.push_back(pc);
	endtask

	task automatic expect_kill(input logic [31:0] pc);
		kill_q.push_back(pc);
	endtask

	task automatic expect_restore(input logic [4:0] rd, input logic [31:0] value);
		rec_q.push_back({rd, value});
	endtask

	task automatic expect_exc(input logic [31:0] pc, input logic [31:0] cause,
		input logic [31:0] mtval);
		exc_q.push_back({pc, cause, mtval});
	endtask

	function automatic int pending();
		return retire_q.size() + kill_q.size() + rec_q.size() + exc_q.size();
	endfunction

	task automatic check_idle();
		if (stall_i || kill_i || retire_i || rec_we_i || exc_valid_i)
			note("a control output is high right after reset");
	endtask

	task automatic check_stall();
		if (stall_i !== 1'b1) mismatch("stall_o with a full buffer", stall_i, 1);
	endtask

	task automatic end_test(input int num);
		if (pending() != 0)
			note($sformatf("test %0d ended with %0d expected events never seen", num, pending()));
		$display("test %0d finished with %0d errors", num, test_errors);
		tests++;
		test_errors = 0;
	endtask

	task automatic final_report(input int assert_fails);
		$display("%0d tests run, %0d errors, %0d assertion failures", tests, errors,
			assert_fails);
	endtask

	// outputs are registered, so the falling edge sees them settled.
	always @(negedge clk_i) begin
		if (rst_n_i) begin
			if (retire_i) begin
				if (retire_q.size() == 0) note("retire pulse with nothing expected");
				else begin
					want = retire_q.pop_front();
					if (retire_pc_i !== want[31:0]) mismatch("retire_pc_o", retire_pc_i, want);
				end
			end
			if (kill_i) begin
				if (retire_q.size() != 0) note("kill came before older entries retired");
				if (kill_q.size() == 0) note("kill pulse with nothing expected");
				else begin
					want = kill_q.pop_front();
					if (kill_pc_i !== want[31:0]) mismatch("kill_pc_o", kill_pc_i, want);
				end
			end
			if (rec_we_i) begin
				if (rec_q.size() == 0) note("restore write with nothing expected");
				else begin
					want = rec_q.pop_front();
					if ({rec_rd_i, rec_value_i} !== want[36:0])
						mismatch("restore rd/value", {rec_rd_i, rec_value_i}, want);
				end
			end
			if (exc_valid_i) begin
				if (exc_q.size() == 0) note("exception report with nothing expected");
				else begin
					want = exc_q.pop_front();
					if ({exc_mepc_i, exc_mcause_i, exc_mtval_i} !== want)
						mismatch("exception triple", {exc_mepc_i, exc_mcause_i, exc_mtval_i},
							want);
				end
			end
		end
	end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2 rst_n_o = 1'b1; // released off the edge, like other inputs.
	end

endmodule

// File: history_buffer_tb.sv
// History buffer testbench
`timescale 1ns/1ps

module history_buffer_tb;

	localparam int CLK_PERIOD_NS   = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_LINE = 40;

	logic clk, rst_n, dec_valid, wb_valid;
	logic [31:0] dec_pc, dec_old_value, wb_pc, wb_cause, wb_mtval;
	logic [4:0] dec_rd;
	logic stall, kill, retire, rec_we, exc_valid;
	logic [31:0] kill_pc, retire_pc, rec_value, exc_mepc, exc_mcause, exc_mtval;
	logic [4:0] rec_rd;
	byte op_q [$];
	logic [31:0] a_q [$], b_q [$], c_q [$], n_q [$];
	bit loaded = 0;
	integer seed = 32'h0814_4506;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	history_buffer_top #(.HF_DEPTH(16)) i_history_buffer_top (
		.clk_i(clk), .rst_n_i(rst_n), .dec_valid_i(dec_valid), .dec_pc_i(dec_pc),
		.dec_rd_i(dec_rd), .dec_old_value_i(dec_old_value), .wb_valid_i(wb_valid),
		.wb_pc_i(wb_pc), .wb_cause_i(wb_cause), .wb_mtval_i(wb_mtval), .stall_o(stall),
		.kill_o(kill), .kill_pc_o(kill_pc), .retire_o(retire), .retire_pc_o(retire_pc),
		.rec_we_o(rec_we), .rec_rd_o(rec_rd), .rec_value_o(rec_value),
		.exc_valid_o(exc_valid), .exc_mepc_o(exc_mepc), .exc_mcause_o(exc_mcause),
		.exc_mtval_o(exc_mtval)
	);

	bind history_buffer_top history_buffer_sva i_history_buffer_sva (.*);

	hf_checker i_checker (
		.clk_i(clk), .rst_n_i(rst_n), .stall_i(stall), .kill_i(kill), .kill_pc_i(kill_pc),
		.retire_i(retire), .retire_pc_i(retire_pc), .rec_we_i(rec_we), .rec_rd_i(rec_rd),
		.rec_value_i(rec_value), .exc_valid_i(exc_valid), .exc_mepc_i(exc_mepc),
		.exc_mcause_i(exc_mcause), .exc_mtval_i(exc_mtval)
	);

	task automatic load_vectors(output bit ok);
		int fd;
		string line;
		byte op;
		logic [31:0] a, b, c, n;
		fd = $fopen("history_buffer_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line[0] != "#" &&
					$sscanf(line, "%c %h %h %h %h", op, a, b, c, n) == 5) begin
					op_q.push_back(op);
					a_q.push_back(a);
					b_q.push_back(b);
					c_q.push_back(c);
					n_q.push_back(n);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic dispatch(input logic [31:0] pc, input logic [4:0] rd, input logic [31:0] old);
		while (stall) begin
			@(posedge clk);
			#2;
		end
		dec_valid = 1'b1;
		dec_pc = pc;
		dec_rd = rd;
		dec_old_value = old;
		@(posedge clk);
		#2 dec_valid = 1'b0;
	endtask

	task automatic writeback(input logic [31:0] pc, input logic [31:0] cause,
		input logic [31:0] mtval);
		wb_valid = 1'b1;
		wb_pc = pc;
		wb_cause = cause;
		wb_mtval = mtval;
		@(posedge clk);
		#2 wb_valid = 1'b0;
	endtask

	// clean writebacks in a random order.
	task automatic shuffled_writebacks(input logic [31:0] base, input int n);
		logic [31:0] pcs [$];
		logic [31:0] tmp;
		int j;
		for (int k = 0; k < n; k++) pcs.push_back(base + 4 * k);
		for (int k = n - 1; k > 0; k--) begin
			j = $unsigned($random(seed)) % (k + 1);
			tmp = pcs[k];
			pcs[k] = pcs[j];
			pcs[j] = tmp;
		end
		foreach (pcs[k]) writeback(pcs[k], 0, 0);
	endtask

	task automatic wait_drained();
		while (i_checker.pending() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// one vector line, either stimulus or expected events.
	task automatic run_line(input int i);
		case (op_q[i])
			"D": for (int k = 0; k < n_q[i]; k++)
				dispatch(a_q[i] + 4 * k, 5'(b_q[i] + k), c_q[i] + k);
			"W": for (int k = 0; k < n_q[i]; k++)
				writeback(a_q[i] + 4 * k, b_q[i], c_q[i]);
			"V": shuffled_writebacks(a_q[i], n_q[i]);
			"R": for (int k = 0; k < n_q[i]; k++)
				i_checker.expect_retire(a_q[i] + 4 * k);
			"X": for (int k = 0; k < n_q[i]; k++)
				i_checker.expect_restore(5'(a_q[i] - k), b_q[i] - k);
			"K": i_checker.expect_kill(a_q[i]);
			"E": i_checker.expect_exc(a_q[i], b_q[i], c_q[i]);
			"H": i_checker.check_stall();
			"S": wait_drained();
			"T": begin
				wait_drained();
				i_checker.end_test(a_q[i]);
			end
			default: $display("unknown vector line %0d skipped", i);
		endcase
	endtask

	initial begin
		bit ok;
		int unsigned sva_fails;
		dec_valid = 1'b0;
		dec_pc = '0;
		dec_rd = '0;
		dec_old_value = '0;
		wb_valid = 1'b0;
		wb_pc = '0;
		wb_cause = '0;
		wb_mtval = '0;
		load_vectors(ok);
		if (!ok) begin
			$display("could not open the vector file");
			$display("sim failed");
			$finish;
		end else begin
			loaded = 1;
			wait (rst_n);
			@(posedge clk);
			#2 i_checker.check_idle();
			for (int i = 0; i < op_q.size(); i++) run_line(i);
			repeat (2) @(posedge clk);
			sva_fails = i_history_buffer_top.i_history_buffer_sva.fail_count;
			i_checker.final_report(sva_fails);
			if (i_checker.errors == 0 && sva_fails == 0) $display("sim passed");
			else $display("sim failed");
			$finish;
		end
	end

	// forty cycles per vector line, plus reset.
	initial begin
		wait (loaded);
		#((op_q.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD_NS);
		$display("watchdog expired before all tests completed");
		$display("sim failed");
		$finish;
	end

endmodule

// File: history_buffer_vectors.txt
# op a b c n, all hex. D pc rd old n; W/V pc cause mtval n; R pc n; X rd old n
# K pc; E pc cause mtval; H stall check; S wait drained; T test number
R 100 0 0 1
D 100 1 a0 1
W 100 0 0 1
T 1 0 0 0
R 200 0 0 8
D 200 1 b0 8
V 200 0 0 8
T 2 0 0 0
K 300 0 0 1
X 7 c4 0 5
E 300 2 dead 1
D 300 3 c0 5
W 300 2 dead 1
T 3 0 0 0
R 400 0 0 2
K 408 0 0 1
X c d4 0 3
E 408 5 bad 1
D 400 8 d0 5
W 408 5 bad 1
W 400 0 0 2
T 4 0 0 0
R 500 0 0 11
D 500 1 e0 10
H 0 0 0 1
W 500 0 0 1
D 540 1 f0 1
W 504 0 0 10
T 5 0 0 0
R 600 0 0 e
K 800 0 0 1
X 3 82 0 3
E 800 1 0 1
D 600 2 60 e
V 600 0 0 e
D 800 1 80 3
W 800 1 0 1
S 0 0 0 1
K 900 0 0 1
X 12 98 0 9
E 900 7 abc 1
D 900 a 90 9
W 900 7 abc 1
T 6 0 0 0

// File: history_buffer_top.f
hf_pkg.sv
hf_store_if.sv
hf_entry_store.sv
hf_ptr_unit.sv
hf_control_fsm.sv
history_buffer_top.sv
history_buffer_sva.sv
hf_checker.sv
tb_clock_gen.sv
history_buffer_tb.sv

// File: Bender.yml
package:
  name: history_buffer

sources:
  - hf_pkg.sv
  - hf_store_if.sv
  - hf_entry_store.sv
  - hf_ptr_unit.sv
  - hf_control_fsm.sv
  - history_buffer_top.sv
  - target: test
    files:
      - history_buffer_sva.sv
      - hf_checker.sv
      - tb_clock_gen.sv
      - history_buffer_tb.sv
